// File: mem_subsystem.f
rtl/mem_pkg.sv
rtl/cache_arbiter.sv
rtl/line_memory.sv
rtl/mem_timing_regs.sv
rtl/mem_subsystem_top.sv
test/tb_mem_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
# The exit status follows the pass message in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_mem_subsystem \
    -f mem_subsystem.f -o tb_mem_subsystem \
    && ./obj_dir/tb_mem_subsystem | tee /dev/stderr | grep -q "^TESTS PASSED$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: test/tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_LATENCY  = (1 << mem_pkg::LAT_BITS) - 1;
    localparam int ACCESS_LIMIT = 2 * MAX_LATENCY + 8;  // May wait behind the other port.
    localparam int RANDOM_OPS   = 48;
    localparam int ACCESS_COUNT = 2 + 2 + 4 + 2 + RANDOM_OPS;
    localparam int CFG_CYCLES   = 40;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + CFG_CYCLES
                                   + ACCESS_COUNT * (ACCESS_LIMIT + 2) + 100;

    typedef logic [mem_pkg::LINE_BITS:0] check_t;  // Wide enough for a whole response.

    logic                   clock;
    logic                   rst_n;
    mem_pkg::mem_bus_req_t  port1_req;
    mem_pkg::mem_bus_resp_t port1_resp;
    mem_pkg::mem_bus_req_t  port2_req;
    mem_pkg::mem_bus_resp_t port2_resp;
    logic                   cfg_wr;
    logic                   cfg_addr;
    mem_pkg::latency_t      cfg_wdata;
    mem_pkg::latency_t      cfg_rdata;

    logic [31:0]                   lfsr_q;
    mem_pkg::line_t                model_mem [mem_pkg::MEM_LINES];  // Expected array.
    logic [mem_pkg::MEM_LINES-1:0] model_valid;
    int                            load_lat_now;
    int                            store_lat_now;
    int                            test_errors;
    int                            pass_count;
    int                            fail_count;

    mem_subsystem_top uut (
        .clock      (clock),
        .rst_n      (rst_n),
        .port1_req  (port1_req),
        .port1_resp (port1_resp),
        .port2_req  (port2_req),
        .port2_resp (port2_resp),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    // Worst case of every access plus setup and a margin.
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken.
    function automatic mem_pkg::line_t random_value(input int n);
        mem_pkg::line_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v[i]   = lfsr_q[0];
        end
        return v;
    endfunction

    function automatic mem_pkg::line_addr_t make_addr(input mem_pkg::mem_index_t idx);
        mem_pkg::line_addr_t addr;
        addr = mem_pkg::line_addr_t'(random_value(mem_pkg::ADDR_BITS));
        addr[mem_pkg::MEM_INDEX_BITS-1:0] = idx;  // Upper bits are don't care.
        return addr;
    endfunction

    task automatic compare_value(input string test_name, input check_t expected,
                                 input check_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %0h, actual %0h", test_name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string test_name);
        if (test_errors == 0) begin
            $display("%s: ok", test_name);
            pass_count++;
        end else begin
            $display("%s: %0d errors", test_name, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    task automatic write_latency(input logic addr, input mem_pkg::latency_t value);
        @(negedge clock);
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = value;
        @(negedge clock);
        cfg_wr    = 1'b0;
    endtask

    task automatic read_latency(input logic addr, output mem_pkg::latency_t value);
        @(negedge clock);
        cfg_addr = addr;
        @(negedge clock);
        value = cfg_rdata;
    endtask

    task automatic drive_port(input int port, input mem_pkg::mem_bus_req_t r);
        if (port == 1) begin
            port1_req = r;
        end else begin
            port2_req = r;
        end
    endtask

    // Raise one request, wait for ready, drop it in the ready cycle.
    task automatic bus_access(input int port, input logic is_store,
                              input mem_pkg::line_addr_t addr, input mem_pkg::line_t wdata,
                              input logic quiet_other, input string test_name,
                              output mem_pkg::line_t rdata, output int cycles);
        mem_pkg::mem_bus_req_t  r;
        mem_pkg::mem_bus_resp_t own;
        mem_pkg::mem_bus_resp_t other;
        logic                   seen;
        r.mem_addr      = addr;
        r.mem_data_out  = is_store ? wdata : '0;
        r.mem_req_load  = ~is_store;
        r.mem_req_store = is_store;
        seen   = 1'b0;
        cycles = 0;
        rdata  = '0;
        @(negedge clock);
        drive_port(port, r);
        while (!seen && cycles < ACCESS_LIMIT) begin
            @(negedge clock);
            cycles++;
            own   = (port == 1) ? port1_resp : port2_resp;
            other = (port == 1) ? port2_resp : port1_resp;
            if (quiet_other) begin
                compare_value(test_name, '0, check_t'(other));  // Idle port sees zeros.
            end
            if (own.mem_ready) begin
                seen  = 1'b1;
                rdata = own.mem_data;
            end
        end
        drive_port(port, '0);
        if (!seen) begin
            $display("%s: port %0d saw no ready within %0d cycles",
                     test_name, port, ACCESS_LIMIT);
            test_errors++;
        end
    endtask

    task automatic store_line(input int port, input mem_pkg::mem_index_t idx,
                              input logic quiet_other, input string test_name,
                              output int cycles);
        mem_pkg::line_t data;
        mem_pkg::line_t ignored;
        data = random_value(mem_pkg::LINE_BITS);
        bus_access(port, 1'b1, make_addr(idx), data, quiet_other, test_name, ignored, cycles);
        model_mem[idx]   = data;
        model_valid[idx] = 1'b1;
    endtask

    task automatic load_check(input int port, input mem_pkg::mem_index_t idx,
                              input logic quiet_other, input string test_name,
                              output int cycles);
        mem_pkg::line_t rdata;
        bus_access(port, 1'b0, make_addr(idx), '0, quiet_other, test_name, rdata, cycles);
        compare_value(test_name, check_t'(model_mem[idx]), check_t'(rdata));
    endtask

    task automatic test_reset_defaults();
        string             name;
        mem_pkg::latency_t value;
        name = "reset_defaults";
        repeat (3) begin
            @(negedge clock);
            compare_value(name, '0, check_t'(port1_resp.mem_ready));
            compare_value(name, '0, check_t'(port2_resp.mem_ready));
        end
        read_latency(1'b0, value);
        compare_value(name, check_t'(mem_pkg::DEFAULT_LATENCY), check_t'(value));
        read_latency(1'b1, value);
        compare_value(name, check_t'(mem_pkg::DEFAULT_LATENCY), check_t'(value));
        write_latency(1'b0, '0);  // Zero reads back as one.
        read_latency(1'b0, value);
        compare_value(name, check_t'(1), check_t'(value));
        write_latency(1'b1, '0);
        read_latency(1'b1, value);
        compare_value(name, check_t'(1), check_t'(value));
        write_latency(1'b0, mem_pkg::DEFAULT_LATENCY);
        write_latency(1'b1, mem_pkg::DEFAULT_LATENCY);
        finish_test(name);
    endtask

    task automatic test_port1_round_trip();
        string name;
        int    cycles;
        name = "port1_round_trip";
        store_line(1, 4'd3, 1'b1, name, cycles);
        load_check(1, 4'd3, 1'b1, name, cycles);
        finish_test(name);
    endtask

    task automatic test_port2_round_trip();
        string name;
        int    cycles;
        name = "port2_round_trip";
        store_line(2, 4'd9, 1'b1, name, cycles);
        load_check(2, 4'd9, 1'b1, name, cycles);
        finish_test(name);
    endtask

    // Port 1 wins, then one idle cycle before port 2 is granted.
    task automatic test_contention();
        string name;
        int    cycles1;
        int    cycles2;
        name = "contention";
        fork
            store_line(1, 4'd5, 1'b0, name, cycles1);
            store_line(2, 4'd12, 1'b0, name, cycles2);
        join
        compare_value(name, check_t'(store_lat_now + 2), check_t'(cycles1));
        compare_value(name, check_t'(2 * store_lat_now + 5), check_t'(cycles2));
        load_check(1, 4'd5, 1'b1, name, cycles1);
        load_check(2, 4'd12, 1'b1, name, cycles2);
        finish_test(name);
    endtask

    task automatic test_latency();
        string name;
        int    cycles;
        name = "latency";
        write_latency(1'b0, 4'd7);
        write_latency(1'b1, 4'd3);
        load_lat_now  = 7;
        store_lat_now = 3;
        store_line(1, 4'd7, 1'b1, name, cycles);
        compare_value(name, check_t'(store_lat_now + 2), check_t'(cycles));
        load_check(2, 4'd7, 1'b1, name, cycles);
        compare_value(name, check_t'(load_lat_now + 2), check_t'(cycles));
        finish_test(name);
    endtask

    task automatic test_random_traffic();
        string               name;
        int                  port;
        int                  cycles;
        logic                port_bit;
        logic                is_store;
        mem_pkg::mem_index_t idx;
        name = "random_traffic";
        for (int n = 0; n < RANDOM_OPS; n++) begin
            port_bit = 1'(random_value(1));
            is_store = 1'(random_value(1));
            idx      = mem_pkg::mem_index_t'(random_value(mem_pkg::MEM_INDEX_BITS));
            port     = port_bit ? 2 : 1;
            if (is_store || !model_valid[idx]) begin  // Never load an unwritten line.
                store_line(port, idx, 1'b1, name, cycles);
                compare_value(name, check_t'(store_lat_now + 2), check_t'(cycles));
            end else begin
                load_check(port, idx, 1'b1, name, cycles);
                compare_value(name, check_t'(load_lat_now + 2), check_t'(cycles));
            end
        end
        finish_test(name);
    endtask

    initial begin
        rst_n         = 1'b0;
        port1_req     = '0;
        port2_req     = '0;
        cfg_wr        = 1'b0;
        cfg_addr      = 1'b0;
        cfg_wdata     = '0;
        lfsr_q        = 32'h48ff;
        model_valid   = '0;
        load_lat_now  = int'(mem_pkg::DEFAULT_LATENCY);
        store_lat_now = int'(mem_pkg::DEFAULT_LATENCY);
        test_errors   = 0;
        pass_count    = 0;
        fail_count    = 0;
        repeat (RESET_CYCLES) @(negedge clock);
        rst_n = 1'b1;

        test_reset_defaults();
        test_port1_round_trip();
        test_port2_round_trip();
        test_contention();
        test_latency();
        test_random_traffic();

        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/mem_subsystem_top.sv
`timescale 1ns/1ns

module mem_subsystem_top (
    input  logic                   clock,
    input  logic                   rst_n,

    // Instruction cache port.
    input  mem_pkg::mem_bus_req_t  port1_req,
    output mem_pkg::mem_bus_resp_t port1_resp,

    // Data cache port.
    input  mem_pkg::mem_bus_req_t  port2_req,
    output mem_pkg::mem_bus_resp_t port2_resp,

    // Latency configuration.
    input  logic                   cfg_wr,
    input  logic                   cfg_addr,
    input  mem_pkg::latency_t      cfg_wdata,
    output mem_pkg::latency_t      cfg_rdata
);

    mem_pkg::mem_bus_req_t  bus_req;
    mem_pkg::mem_bus_resp_t bus_resp;
    mem_pkg::mem_timing_t   timing;

    cache_arbiter u_arbiter (
        .clock (clock),
        .rst_n (rst_n),
        .req1  (port1_req),
        .resp1 (port1_resp),
        .req2  (port2_req),
        .resp2 (port2_resp),
        .req   (bus_req),
        .resp  (bus_resp)
    );

    // Stand-in for the L2.
    line_memory u_memory (
        .clock    (clock),
        .rst_n    (rst_n),
        .bus_req  (bus_req),
        .bus_resp (bus_resp),
        .timing   (timing)
    );

    mem_timing_regs u_timing (
        .clock     (clock),
        .rst_n     (rst_n),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .timing    (timing)
    );

endmodule

// File: rtl/mem_timing_regs.sv
`timescale 1ns/1ns

module mem_timing_regs (
    input  logic                 clock,
    input  logic                 rst_n,
    input  logic                 cfg_wr,
    input  logic                 cfg_addr,   // 0 load, 1 store.
    input  mem_pkg::latency_t    cfg_wdata,
    output mem_pkg::latency_t    cfg_rdata,
    output mem_pkg::mem_timing_t timing
);

    mem_pkg::latency_t load_lat_q;
    mem_pkg::latency_t store_lat_q;
    mem_pkg::latency_t wdata_fixed;

    // A zero latency would skip the busy state; store it as one.
    assign wdata_fixed = (cfg_wdata == '0) ? mem_pkg::latency_t'(1) : cfg_wdata;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            load_lat_q  <= mem_pkg::DEFAULT_LATENCY;
            store_lat_q <= mem_pkg::DEFAULT_LATENCY;
        end else if (cfg_wr) begin
            if (cfg_addr) begin
                store_lat_q <= wdata_fixed;
            end else begin
                load_lat_q <= wdata_fixed;
            end
        end
    end

    assign cfg_rdata = cfg_addr ? store_lat_q : load_lat_q;  // Readback.

    assign timing.load_latency  = load_lat_q;
    assign timing.store_latency = store_lat_q;

endmodule

// File: rtl/line_memory.sv
`timescale 1ns/1ns

module line_memory (
    input  logic                   clock,
    input  logic                   rst_n,
    input  mem_pkg::mem_bus_req_t  bus_req,
    output mem_pkg::mem_bus_resp_t bus_resp,
    input  mem_pkg::mem_timing_t   timing
);

    mem_pkg::line_t         mem [mem_pkg::MEM_LINES];  // Backing lines.

    mem_pkg::timing_state_t state_q;
    mem_pkg::latency_t      count_q;
    mem_pkg::mem_index_t    index_q;   // Line of the transaction in flight.
    logic                   is_load_q;

    logic                   want;
    logic                   accept;
    mem_pkg::mem_index_t    bus_index;
    mem_pkg::latency_t      start_count;

    assign want      = bus_req.mem_req_load | bus_req.mem_req_store;
    assign accept    = (state_q == mem_pkg::idle) && want;
    assign bus_index = bus_req.mem_addr[mem_pkg::MEM_INDEX_BITS-1:0];

    // Latency of the operation being accepted.
    assign start_count = bus_req.mem_req_load ? timing.load_latency
                                              : timing.store_latency;

    // Ready in the cycle after accept edge plus latency.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state_q <= mem_pkg::idle;
            count_q <= '0;
        end else begin
            case (state_q)
                mem_pkg::idle: begin
                    if (want) begin
                        state_q <= mem_pkg::busy;
                        count_q <= start_count;
                    end
                end
                mem_pkg::busy: begin
                    if (count_q <= mem_pkg::latency_t'(1)) begin
                        state_q <= mem_pkg::respond;
                    end else begin
                        count_q <= count_q - mem_pkg::latency_t'(1);
                    end
                end
                mem_pkg::respond: begin
                    state_q <= mem_pkg::idle;  // One-cycle ready pulse.
                end
                default: begin
                    state_q <= mem_pkg::idle;
                end
            endcase
        end
    end

    // Operation capture at acceptance.
    // A request with both levels up is treated as a load that also writes.
    always_ff @(posedge clock) begin
        if (accept) begin
            index_q   <= bus_index;
            is_load_q <= bus_req.mem_req_load;
        end
    end

    // Stores land in the array as soon as they are taken.
    always_ff @(posedge clock) begin
        if (rst_n && accept && bus_req.mem_req_store) begin
            mem[bus_index] <= bus_req.mem_data_out;
        end
    end

    // Load data is read while ready is up.
    always_comb begin
        bus_resp = '0;
        if (state_q == mem_pkg::respond) begin
            bus_resp.mem_ready = 1'b1;
            if (is_load_q) begin
                bus_resp.mem_data = mem[index_q];
            end
        end
    end

endmodule

// File: rtl/cache_arbiter.sv
`timescale 1ns/1ns

module cache_arbiter (
    input  logic                   clock,
    input  logic                   rst_n,

    // Instruction side cache.
    input  mem_pkg::mem_bus_req_t  req1,
    output mem_pkg::mem_bus_resp_t resp1,

    // Data side cache.
    input  mem_pkg::mem_bus_req_t  req2,
    output mem_pkg::mem_bus_resp_t resp2,

    // Next-level bus.
    output mem_pkg::mem_bus_req_t  req,
    input  mem_pkg::mem_bus_resp_t resp
);

    logic [1:0] grant_q;  // One-hot with bit 0 for port 1.
    logic [1:0] grant_d;
    logic       want1;
    logic       want2;

    assign want1 = req1.mem_req_load | req1.mem_req_store;
    assign want2 = req2.mem_req_load | req2.mem_req_store;

    // A new grant only from idle, so a finished port gets one free cycle
    // to drop its level before anyone can be granted again.
    always_comb begin
        grant_d = grant_q;
        if (grant_q == 2'b00) begin
            if (want1) begin
                grant_d = 2'b01;  // Port 1 wins ties.
            end else if (want2) begin
                grant_d = 2'b10;
            end
        end else if (resp.mem_ready) begin
            grant_d = 2'b00;      // Released at the end of the ready cycle.
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            grant_q <= 2'b00;
        end else begin
            grant_q <= grant_d;
        end
    end

    // Bus request follows the granted port.
    always_comb begin
        case (grant_q)
            2'b01: begin
                req = req1;
            end
            2'b10: begin
                req = req2;
            end
            default: begin
                req = '0;  // No load, no store.
            end
        endcase
    end

    // Response goes back to the owner only; the other port sees zeros.
    always_comb begin
        resp1 = '0;
        resp2 = '0;
        if (grant_q[0]) begin
            resp1 = resp;
        end
        if (grant_q[1]) begin
            resp2 = resp;
        end
    end

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

    // Line geometry.
    localparam int LINE_BITS      = 512;  // 64 bytes.
    localparam int ADDR_BITS      = 58;   // 64-bit byte address less the line offset.
    localparam int MEM_INDEX_BITS = 4;
    localparam int MEM_LINES      = 1 << MEM_INDEX_BITS;

    // Latency fields of the timing block.
    localparam int LAT_BITS = 4;

    typedef logic [LINE_BITS-1:0]      line_t;
    typedef logic [ADDR_BITS-1:0]      line_addr_t;
    typedef logic [LAT_BITS-1:0]       latency_t;
    typedef logic [MEM_INDEX_BITS-1:0] mem_index_t;

    localparam latency_t DEFAULT_LATENCY = latency_t'(2);

    // Request from a cache port, or from the arbiter onto the shared bus.
    typedef struct packed {
        line_addr_t mem_addr;
        line_t      mem_data_out;   // Store data.
        logic       mem_req_load;
        logic       mem_req_store;
    } mem_bus_req_t;

    // Answer on the bus. Ready is a one-cycle pulse.
    typedef struct packed {
        line_t mem_data;
        logic  mem_ready;
    } mem_bus_resp_t;

    typedef struct packed {
        latency_t load_latency;
        latency_t store_latency;
    } mem_timing_t;

    // Memory model sequencing.
    typedef enum logic [1:0] {
        idle    = 2'd0,
        busy    = 2'd1,
        respond = 2'd2
    } timing_state_t;

endpackage
